//--- hdl/axi_10geth.sv
/* DMA to 10G MAC bridge, 64-bit AXI-Stream on both sides
   Single clock domain, mm2s_clk, with asynchronous active-low reset
   txc carries one control word per frame, rxs one status word per frame */
`timescale 1ns/1ps
`include "axi_eth_defines.svh"

module axi_10geth
(
   input  logic                         mm2s_clk,
   input  logic                         arst_n,

   // DMA transmit control and data
   input  axi_eth_pkg::word_t           txc_tdata,
   input  logic [`AXI_ETH_WORD_W/8-1:0] txc_tkeep,
   input  logic                         txc_tlast,
   input  logic                         txc_tvalid,
   output logic                         txc_tready,
   input  axi_eth_pkg::data_t           txd_tdata,
   input  axi_eth_pkg::keep_t           txd_tkeep,
   input  logic                         txd_tlast,
   input  logic                         txd_tvalid,
   output logic                         txd_tready,

   // MAC transmit
   output axi_eth_pkg::data_t           tx_axis_mac_tdata,
   output axi_eth_pkg::keep_t           tx_axis_mac_tkeep,
   output logic                         tx_axis_mac_tlast,
   output logic                         tx_axis_mac_tuser,
   output logic                         tx_axis_mac_tvalid,
   input  logic                         tx_axis_mac_tready,

   // MAC receive
   input  axi_eth_pkg::data_t           rx_axis_mac_tdata,
   input  axi_eth_pkg::keep_t           rx_axis_mac_tkeep,
   input  logic                         rx_axis_mac_tlast,
   input  logic                         rx_axis_mac_tuser,
   input  logic                         rx_axis_mac_tvalid,
   output logic                         rx_axis_mac_tready,

   // DMA receive data and status
   output axi_eth_pkg::data_t           rxd_tdata,
   output axi_eth_pkg::keep_t           rxd_tkeep,
   output logic                         rxd_tlast,
   output logic                         rxd_tvalid,
   input  logic                         rxd_tready,
   output axi_eth_pkg::word_t           rxs_tdata,
   output logic [`AXI_ETH_WORD_W/8-1:0] rxs_tkeep,
   output logic                         rxs_tlast,
   output logic                         rxs_tvalid,
   input  logic                         rxs_tready
);

   axi_eth_ofm ofm0 (.*);   // Transmit, port names match top level
   axi_eth_ifm ifm0 (.*);   // Receive with status queue

endmodule

//--- hdl/axi_eth_ifm.sv
/* Receive path, MAC to DMA
   Frames pass to rxd combinationally, one status word per frame goes to rxs
   A last beat is held off while the status queue is full
   Byte count wraps above 65535 bytes */
`timescale 1ns/1ps
`include "axi_eth_defines.svh"

module axi_eth_ifm
(
   input  logic                         mm2s_clk,
   input  logic                         arst_n,

   // From MAC
   input  axi_eth_pkg::data_t           rx_axis_mac_tdata,
   input  axi_eth_pkg::keep_t           rx_axis_mac_tkeep,
   input  logic                         rx_axis_mac_tlast,
   input  logic                         rx_axis_mac_tuser,   // MAC bad-frame flag
   input  logic                         rx_axis_mac_tvalid,
   output logic                         rx_axis_mac_tready,

   // Frame data to DMA
   output axi_eth_pkg::data_t           rxd_tdata,
   output axi_eth_pkg::keep_t           rxd_tkeep,
   output logic                         rxd_tlast,
   output logic                         rxd_tvalid,
   input  logic                         rxd_tready,

   // Status words to DMA
   output axi_eth_pkg::word_t           rxs_tdata,
   output logic [`AXI_ETH_WORD_W/8-1:0] rxs_tkeep,
   output logic                         rxs_tlast,
   output logic                         rxs_tvalid,
   input  logic                         rxs_tready
);

   axi_eth_pkg::ifm_state_t state;
   axi_eth_pkg::byte_cnt_t  byte_cnt;     // Bytes accepted so far in frame
   axi_eth_pkg::byte_cnt_t  cnt_base;
   axi_eth_pkg::byte_cnt_t  frame_total;  // Count including current beat
   axi_eth_pkg::word_t      sts_word;

   logic sts_full;
   logic stall;       // Last beat waiting for queue space
   logic beat_fire;
   logic push;

   // Number of enabled bytes in one beat
   function automatic axi_eth_pkg::byte_cnt_t keep_bytes
   (
      input axi_eth_pkg::keep_t keep
   );
      axi_eth_pkg::byte_cnt_t n;
      n = '0;
      for (int i = 0; i < `AXI_ETH_KEEP_W; i++)
         n = n + keep[i];
      return n;
   endfunction

   assign stall = rx_axis_mac_tvalid && rx_axis_mac_tlast && sts_full;

   assign rxd_tvalid         = rx_axis_mac_tvalid && !stall;
   assign rx_axis_mac_tready = rxd_tready && !stall;
   assign rxd_tdata          = rx_axis_mac_tdata;
   assign rxd_tkeep          = rx_axis_mac_tkeep;
   assign rxd_tlast          = rx_axis_mac_tlast;

   assign beat_fire = rx_axis_mac_tvalid && rx_axis_mac_tready;
   assign push      = beat_fire && rx_axis_mac_tlast;   // Status queued on last-beat edge

   // First beat restarts the count
   assign cnt_base    = (state == axi_eth_pkg::IFM_IDLE) ? '0 : byte_cnt;
   assign frame_total = cnt_base + keep_bytes(rx_axis_mac_tkeep);

   // Status word, bad flag on top, length at bottom
   always_comb
   begin
      sts_word                     = '0;
      sts_word[`AXI_ETH_WORD_W-1]  = rx_axis_mac_tuser;
      sts_word[`AXI_ETH_CNT_W-1:0] = frame_total;
   end

   always_ff @(posedge mm2s_clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= axi_eth_pkg::IFM_IDLE;
      else if (beat_fire)
         state <= rx_axis_mac_tlast ? axi_eth_pkg::IFM_IDLE : axi_eth_pkg::IFM_FRAME;
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (beat_fire)
         byte_cnt <= frame_total;   // Ignored once back in IFM_IDLE
   end

   axi_eth_sts_fifo #(.DEPTH(`AXI_ETH_STS_DEPTH)) sts_fifo0
   (
      .mm2s_clk   (mm2s_clk),
      .arst_n     (arst_n),
      .push       (push),
      .push_word  (sts_word),
      .full       (sts_full),
      .rxs_tdata  (rxs_tdata),
      .rxs_tkeep  (rxs_tkeep),
      .rxs_tlast  (rxs_tlast),
      .rxs_tvalid (rxs_tvalid),
      .rxs_tready (rxs_tready)
   );

   // Byte count relies on contiguous keep
   a_keep_contig: assert property (@(posedge mm2s_clk) disable iff (!arst_n)
      rx_axis_mac_tvalid |-> (rx_axis_mac_tkeep & (rx_axis_mac_tkeep + 1'b1)) == '0)
      else $error("rx keep not contiguous from bit 0");

   // MAC holds a refused beat unchanged, the stall depends on its last flag
   a_rx_hold: assert property (@(posedge mm2s_clk) disable iff (!arst_n)
      rx_axis_mac_tvalid && !rx_axis_mac_tready |=>
         rx_axis_mac_tvalid && $stable(rx_axis_mac_tlast) && $stable(rx_axis_mac_tkeep))
      else $error("MAC beat dropped or changed before it was taken");

endmodule

//--- hdl/axi_eth_ofm.sv
/* Transmit path, DMA to MAC
   Every txd frame is preceded by one control word on txc (flag 31:28, mark-bad bit 0)
   Frames with a wrong flag are read from txd and thrown away
   Forwarding is combinational, tx_axis_mac_tready reaches txd_tready in the same cycle */
`timescale 1ns/1ps
`include "axi_eth_defines.svh"

module axi_eth_ofm
(
   input  logic                         mm2s_clk,
   input  logic                         arst_n,

   // Control words from DMA
   input  axi_eth_pkg::word_t           txc_tdata,
   input  logic [`AXI_ETH_WORD_W/8-1:0] txc_tkeep,
   input  logic                         txc_tlast,
   input  logic                         txc_tvalid,
   output logic                         txc_tready,

   // Frame data from DMA
   input  axi_eth_pkg::data_t           txd_tdata,
   input  axi_eth_pkg::keep_t           txd_tkeep,
   input  logic                         txd_tlast,
   input  logic                         txd_tvalid,
   output logic                         txd_tready,

   // To MAC
   output axi_eth_pkg::data_t           tx_axis_mac_tdata,
   output axi_eth_pkg::keep_t           tx_axis_mac_tkeep,
   output logic                         tx_axis_mac_tlast,
   output logic                         tx_axis_mac_tuser,
   output logic                         tx_axis_mac_tvalid,
   input  logic                         tx_axis_mac_tready
);

   axi_eth_pkg::ofm_state_t state;
   axi_eth_pkg::ofm_state_t state_nxt;

   logic mark_bad;   // Latched bit 0 of current control word
   logic flag_ok;    // Control word asks for forwarding
   logic ctrl_fire;
   logic txd_fire;
   logic fwd;        // In OFM_DATA
   logic drop;       // In OFM_DROP

   // Control word decode
   assign flag_ok   = (txc_tdata[31:28] == `AXI_ETH_CTRL_FLAG);
   assign ctrl_fire = txc_tvalid && txc_tready;

   assign fwd  = (state == axi_eth_pkg::OFM_DATA);
   assign drop = (state == axi_eth_pkg::OFM_DROP);

   // Handshake steering
   assign txc_tready         = (state == axi_eth_pkg::OFM_CTRL);
   assign txd_tready         = fwd ? tx_axis_mac_tready : drop;
   assign tx_axis_mac_tvalid = fwd && txd_tvalid;   // Nothing offered while dropping
   assign txd_fire           = txd_tvalid && txd_tready;

   // Payload straight through, zero latency
   assign tx_axis_mac_tdata = txd_tdata;
   assign tx_axis_mac_tkeep = txd_tkeep;
   assign tx_axis_mac_tlast = txd_tlast;
   assign tx_axis_mac_tuser = fwd && txd_tlast && mark_bad;   // Bad marker on last beat only

   always_comb
   begin
      state_nxt = state;
      case (state)
         axi_eth_pkg::OFM_CTRL:
            if (ctrl_fire)
            begin
               state_nxt = flag_ok ? axi_eth_pkg::OFM_DATA : axi_eth_pkg::OFM_DROP;
            end
         axi_eth_pkg::OFM_DATA,
         axi_eth_pkg::OFM_DROP:
            if (txd_fire && txd_tlast)   // End of frame, back to control
            begin
               state_nxt = axi_eth_pkg::OFM_CTRL;
            end
         default:
            state_nxt = axi_eth_pkg::OFM_CTRL;
      endcase
   end

   always_ff @(posedge mm2s_clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= axi_eth_pkg::OFM_CTRL;
      else
         state <= state_nxt;
   end

   // Only read in OFM_DATA, loaded with every control word
   always_ff @(posedge mm2s_clk)
   begin
      if (ctrl_fire)
         mark_bad <= txc_tdata[0];
   end

   // DMA holds a refused data beat unchanged
   a_txd_hold: assert property (@(posedge mm2s_clk) disable iff (!arst_n)
      txd_tvalid && !txd_tready |=> txd_tvalid && $stable(txd_tdata) && $stable(txd_tlast))
      else $error("txd beat dropped or changed before it was taken");

   // DMA never offers an empty data beat
   a_txd_keep: assert property (@(posedge mm2s_clk) disable iff (!arst_n)
      txd_tvalid |-> txd_tkeep != '0)
      else $error("txd beat with no bytes enabled");

   // Control word is one full beat
   a_txc_single: assert property (@(posedge mm2s_clk) disable iff (!arst_n)
      ctrl_fire |-> txc_tlast && (&txc_tkeep))
      else $error("Control word not a single full beat");

endmodule

//--- hdl/axi_eth_pkg.sv
/* Shared types of the bridge
   Widths come from the defines header */
`include "axi_eth_defines.svh"

package axi_eth_pkg;

   typedef logic [`AXI_ETH_DATA_W-1:0] data_t;     // One data beat
   typedef logic [`AXI_ETH_KEEP_W-1:0] keep_t;     // Byte enables
   typedef logic [`AXI_ETH_WORD_W-1:0] word_t;     // Control or status word
   typedef logic [`AXI_ETH_CNT_W-1:0]  byte_cnt_t; // Frame length in bytes

   // Transmit FSM
   typedef enum logic [1:0]
   {
      OFM_CTRL,   // Waiting for control word
      OFM_DATA,   // Forwarding frame to MAC
      OFM_DROP    // Discarding frame
   } ofm_state_t;

   // Receive FSM, marks first beat of a frame
   typedef enum logic
   {
      IFM_IDLE,
      IFM_FRAME
   } ifm_state_t;

endpackage

//--- hdl/axi_eth_sts_fifo.sv
/* Status word queue feeding rxs through an output register
   Holds DEPTH words in total, output register included
   DEPTH must be a power of two, at least 2 */
`timescale 1ns/1ps
`include "axi_eth_defines.svh"

module axi_eth_sts_fifo #(
   parameter int unsigned DEPTH = `AXI_ETH_STS_DEPTH
)
(
   input  logic                         mm2s_clk,
   input  logic                         arst_n,
   input  logic                         push,
   input  axi_eth_pkg::word_t           push_word,
   output logic                         full,
   output axi_eth_pkg::word_t           rxs_tdata,
   output logic [`AXI_ETH_WORD_W/8-1:0] rxs_tkeep,
   output logic                         rxs_tlast,
   output logic                         rxs_tvalid,
   input  logic                         rxs_tready
);

   localparam int AW = $clog2(DEPTH);
   localparam int CW = AW + 1;

   axi_eth_pkg::word_t mem [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] mem_cnt;   // Words still in the buffer
   logic          pop_mem;   // Move head into output register

   assign pop_mem = (mem_cnt != '0) && (!rxs_tvalid || rxs_tready);
   assign full    = (mem_cnt + CW'(rxs_tvalid)) == CW'(DEPTH);

   assign rxs_tkeep = '1;     // Status is always a whole word
   assign rxs_tlast = 1'b1;   // Single-beat packet

   always_ff @(posedge mm2s_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         mem_cnt    <= '0;
         rxs_tvalid <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
         if (pop_mem)
            rd_ptr <= rd_ptr + 1'b1;
         mem_cnt <= mem_cnt + CW'(push) - CW'(pop_mem);
         if (pop_mem)
            rxs_tvalid <= 1'b1;
         else if (rxs_tready)
            rxs_tvalid <= 1'b0;
      end
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (push)
         mem[wr_ptr] <= push_word;
      if (pop_mem)
         rxs_tdata <= mem[rd_ptr];
   end

   // A push into a full queue would overwrite a waiting word
   a_no_overflow: assert property (@(posedge mm2s_clk) disable iff (!arst_n)
      push |-> !full)
      else $error("Status pushed into full queue");

endmodule

//--- include/axi_eth_defines.svh
/* Widths and constants of the DMA to 10G MAC bridge
   AXI_ETH_STS_DEPTH must be a power of two, at least 2 */
`ifndef AXI_ETH_DEFINES_SVH
`define AXI_ETH_DEFINES_SVH

// Data path of DMA and MAC streams
`define AXI_ETH_DATA_W      64
`define AXI_ETH_KEEP_W      8

// Control and status words, one beat each
`define AXI_ETH_WORD_W      32
`define AXI_ETH_CNT_W       16   // Byte count field of the status word

// Frames whose status may wait while rxs is stalled
`define AXI_ETH_STS_DEPTH   4

// Expected value of control word bits 31:28
`define AXI_ETH_CTRL_FLAG   4'hA

`endif

//--- verification/axi_10geth_tb.sv
/* Table-driven testbench of the DMA to 10G MAC bridge
   Data and ready patterns come from a Galois LFSR with a fixed seed
   Inputs change 2 ns after the rising edge, outputs are sampled at the falling edge */
`timescale 1ns/1ps
`include "axi_eth_defines.svh"

module axi_10geth_tb;

   localparam int NUM_ROWS  = 12;
   localparam int MAX_BEATS = 6;
   localparam int WATCH_NS  = (NUM_ROWS + 1) * MAX_BEATS * 8 * 40;   // Burst counted as a row

   typedef struct packed
   {
      logic       rx;          // Receive frame, else transmit
      logic [2:0] beats;
      logic [7:0] last_keep;
      logic [3:0] flag;        // Control flag, tx only
      logic       bad;         // Mark-bad or MAC bad bit
   } frame_t;

   typedef struct packed
   {
      axi_eth_pkg::data_t data;
      axi_eth_pkg::keep_t keep;
      logic               last;
      logic               user;
   } beat_t;

   logic                         mm2s_clk;
   logic                         arst_n = 1'b0;
   axi_eth_pkg::word_t           txc_tdata = '0;
   logic [`AXI_ETH_WORD_W/8-1:0] txc_tkeep = '1;   // Control word always whole
   logic                         txc_tlast = 1'b1;
   logic                         txc_tvalid = 1'b0;
   axi_eth_pkg::data_t           txd_tdata = '0, rx_axis_mac_tdata = '0;
   axi_eth_pkg::keep_t           txd_tkeep = '1, rx_axis_mac_tkeep = '1;
   logic                         txd_tlast = 1'b0, txd_tvalid = 1'b0;
   logic                         rx_axis_mac_tlast = 1'b0, rx_axis_mac_tuser = 1'b0;
   logic                         rx_axis_mac_tvalid = 1'b0;
   logic                         tx_axis_mac_tready = 1'b0, rxd_tready = 1'b0;
   logic                         rxs_tready = 1'b0;

   // DUT outputs
   logic                         txc_tready, txd_tready, rx_axis_mac_tready;
   axi_eth_pkg::data_t           tx_axis_mac_tdata, rxd_tdata;
   axi_eth_pkg::keep_t           tx_axis_mac_tkeep, rxd_tkeep;
   logic                         tx_axis_mac_tlast, tx_axis_mac_tuser, tx_axis_mac_tvalid;
   logic                         rxd_tlast, rxd_tvalid;
   axi_eth_pkg::word_t           rxs_tdata;
   logic [`AXI_ETH_WORD_W/8-1:0] rxs_tkeep;
   logic                         rxs_tlast, rxs_tvalid;

   beat_t              exp_mac [$];         // Beats due at the MAC
   beat_t              exp_rxd [$];
   axi_eth_pkg::word_t exp_rxs [$];         // Status words, frame order
   logic               burst = 1'b0;        // rxs held off, rxd always ready
   logic [31:0]        lfsr_state = 32'h2a84_d70d;

   // rx, beats, last keep, flag, bad
   frame_t rows [NUM_ROWS] = '{
      {1'b0, 3'd1, 8'h0F, 4'hA, 1'b0},
      {1'b0, 3'd3, 8'hFF, 4'hA, 1'b1},
      {1'b0, 3'd2, 8'h3F, 4'h5, 1'b1},     // Wrong flag, dropped
      {1'b0, 3'd6, 8'h01, 4'hA, 1'b0},
      {1'b1, 3'd2, 8'hFF, 4'h0, 1'b0},
      {1'b1, 3'd3, 8'h03, 4'h0, 1'b1},
      {1'b0, 3'd4, 8'h07, 4'h0, 1'b0},     // Dropped
      {1'b0, 3'd5, 8'h7F, 4'hA, 1'b1},
      {1'b1, 3'd6, 8'h7F, 4'h0, 1'b0},
      {1'b1, 3'd1, 8'h01, 4'h0, 1'b1},
      {1'b0, 3'd1, 8'h1F, 4'hE, 1'b1},     // Dropped, next one must pass
      {1'b0, 3'd2, 8'h03, 4'hA, 1'b1}
   };

   axi_10geth dut0 (.*);

   // Galois LFSR, one step per bit taken
   function automatic logic [63:0] lfsr_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v          = {v[62:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      end
      return v;
   endfunction

   function automatic int count_ones(input logic [7:0] k);
      int n;
      n = 0;
      for (int i = 0; i < 8; i++)
         n += k[i];
      return n;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED time %0t: %s is %0h, expected %0h",
                             $time, name, got, exp));
   endtask

   task automatic drain();
      while (exp_mac.size() != 0 || exp_rxd.size() != 0 || exp_rxs.size() != 0)
      begin
         @(posedge mm2s_clk);
         #2;
      end
   endtask

   // One frame of the table, expected results queued before driving
   task automatic send_frame(input frame_t f, input logic stall_check);
      beat_t              b;
      axi_eth_pkg::word_t sts;
      logic [63:0]        pad;
      logic               fwd;
      fwd = !f.rx && (f.flag == `AXI_ETH_CTRL_FLAG);
      if (f.rx)
      begin
         sts       = '0;
         sts[31]   = f.bad;
         sts[15:0] = 8 * (f.beats - 1) + count_ones(f.last_keep);   // Full beats plus tail
         exp_rxs.push_back(sts);
      end
      else
      begin
         pad        = lfsr_bits(27);   // Bits the decoder ignores
         txc_tdata  = {f.flag, pad[26:0], f.bad};
         txc_tvalid = 1'b1;
         @(negedge mm2s_clk);
         while (!txc_tready)
            @(negedge mm2s_clk);
         @(posedge mm2s_clk);
         #2;
         txc_tvalid = 1'b0;
      end
      for (int i = 0; i < f.beats; i++)
      begin
         b.data = lfsr_bits(64);
         b.last = (i == f.beats - 1);
         b.keep = b.last ? f.last_keep : 8'hFF;
         b.user = b.last && f.bad;   // Bad marker on the last beat only
         if (fwd)
            exp_mac.push_back(b);
         if (f.rx)
            exp_rxd.push_back(b);
         txd_tdata          = b.data;   // Same beat on both buses, one valid
         txd_tkeep          = b.keep;
         txd_tlast          = b.last;
         txd_tvalid         = !f.rx;
         rx_axis_mac_tdata  = b.data;
         rx_axis_mac_tkeep  = b.keep;
         rx_axis_mac_tlast  = b.last;
         rx_axis_mac_tuser  = b.user;
         rx_axis_mac_tvalid = f.rx;
         if (stall_check && b.last)
         begin
            // Queue full, last beat refused
            repeat (4)
            begin
               @(negedge mm2s_clk);
               check_val("rx_axis_mac_tready", rx_axis_mac_tready, 1'b0);
               check_val("rxd_tvalid", rxd_tvalid, 1'b0);
               check_val("rxs_tvalid", rxs_tvalid, 1'b1);
            end
            @(posedge mm2s_clk);
            #2;
            burst = 1'b0;   // rxs drains from here
         end
         @(negedge mm2s_clk);
         while (!(f.rx ? rx_axis_mac_tready : txd_tready))
            @(negedge mm2s_clk);
         @(posedge mm2s_clk);
         #2;
      end
      txd_tvalid         = 1'b0;
      rx_axis_mac_tvalid = 1'b0;
   endtask

   initial
   begin
      mm2s_clk = 1'b0;
      forever #20 mm2s_clk = ~mm2s_clk;
   end

   // Back-pressure, drawn at the falling edge, driven after the rising edge
   initial
   begin
      logic [2:0] r;
      logic       hold;
      forever
      begin
         @(negedge mm2s_clk);
         r[0] = lfsr_bits(2) != 0;   // Ready three cycles in four
         r[1] = lfsr_bits(2) != 0;
         r[2] = lfsr_bits(2) != 0;
         hold = burst;
         @(posedge mm2s_clk);
         #2;
         tx_axis_mac_tready = r[0];
         rxd_tready         = r[1] || hold;
         rxs_tready         = r[2] && !hold;
      end
   end

   // Output streams, compared beat by beat
   initial
   begin
      beat_t b;
      forever
      begin
         @(negedge mm2s_clk);
         if (tx_axis_mac_tvalid && exp_mac.size() == 0)
            abort_run("The MAC was offered a beat while no forwarded frame was pending");
         else if (tx_axis_mac_tvalid && tx_axis_mac_tready)
         begin
            b = exp_mac.pop_front();
            check_val("tx_axis_mac_tdata", tx_axis_mac_tdata, b.data);
            check_val("tx_axis_mac_tkeep", tx_axis_mac_tkeep, b.keep);
            check_val("tx_axis_mac_tlast", tx_axis_mac_tlast, b.last);
            check_val("tx_axis_mac_tuser", tx_axis_mac_tuser, b.user);
         end
         if (rxd_tvalid && exp_rxd.size() == 0)
            abort_run("A beat appeared on rxd although no MAC frame was sent");
         else if (rxd_tvalid && rxd_tready)
         begin
            b = exp_rxd.pop_front();
            check_val("rxd_tdata", rxd_tdata, b.data);
            check_val("rxd_tkeep", rxd_tkeep, b.keep);
            check_val("rxd_tlast", rxd_tlast, b.last);
         end
         if (rxs_tvalid && exp_rxs.size() == 0)
            abort_run("A status word appeared on rxs with no frame left to report");
         else if (rxs_tvalid && rxs_tready)
         begin
            check_val("rxs_tdata", rxs_tdata, exp_rxs.pop_front());
            check_val("rxs_tkeep", rxs_tkeep, 4'hF);
            check_val("rxs_tlast", rxs_tlast, 1'b1);
         end
      end
   end

   initial
   begin
      #(WATCH_NS);
      $display("Timeout after %0d ns, a handshake never completed and the run hung", WATCH_NS);
      $display("Simulation finished: FAIL");
      $fatal(1, "Watchdog expired");
   end

   initial
   begin
      repeat (2) @(posedge mm2s_clk);
      #2;
      arst_n = 1'b1;
      @(negedge mm2s_clk);   // Idle outputs after reset
      check_val("tx_axis_mac_tvalid", tx_axis_mac_tvalid, 1'b0);
      check_val("rxd_tvalid", rxd_tvalid, 1'b0);
      check_val("rxs_tvalid", rxs_tvalid, 1'b0);
      check_val("txc_tready", txc_tready, 1'b1);
      @(posedge mm2s_clk);
      #2;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         send_frame(rows[r], 1'b0);
         drain();
      end
      // Five one-beat rx frames against a stalled rxs
      burst = 1'b1;
      repeat (2) @(posedge mm2s_clk);
      #2;
      for (int i = 0; i < 5; i++)
         send_frame({1'b1, 3'd1, 8'hFF >> i, 4'h0, i[0]}, i == 4);
      drain();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+include
hdl/axi_eth_pkg.sv
hdl/axi_eth_sts_fifo.sv
hdl/axi_eth_ofm.sv
hdl/axi_eth_ifm.sv
hdl/axi_10geth.sv
verification/axi_10geth_tb.sv
